// File: files.f
logic/mem_banked_pkg.sv
logic/bank_arbiter.sv
logic/bank_xbar.sv
logic/read_resp_pipe.sv
logic/mem_banked_top.sv
testbench/bank_model.sv
testbench/tb_mem_banked.sv

// File: testbench/tb_mem_banked.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_banked;

  localparam int unsigned NumBanks   = 4;
  localparam int unsigned MemLatency = 2;
  localparam int unsigned ClkPeriod  = 40;
  localparam int unsigned Timeout    = 200;
  localparam int          Seed       = 57821;
  localparam int unsigned ByteOff    = mem_banked_pkg::ByteOffsetWidth;
  localparam int unsigned SelWidth   = $clog2(NumBanks);
  localparam int unsigned WordLsb    = ByteOff + SelWidth;
  // Word index over all banks
  localparam int unsigned IdxWidth   = SelWidth + mem_banked_pkg::BankAddrWidth;

  logic clk;
  logic rst_n;
  logic always_grant;
  logic wr_req;
  logic wr_gnt;
  logic rd_req;
  logic rd_gnt;
  logic rd_valid;
  mem_banked_pkg::addr_t wr_addr;
  mem_banked_pkg::addr_t rd_addr;
  mem_banked_pkg::word_t wr_data;
  mem_banked_pkg::word_t rd_data;
  mem_banked_pkg::strb_t wr_strb;
  logic [NumBanks-1:0] mem_req;
  logic [NumBanks-1:0] mem_gnt;
  logic [NumBanks-1:0] mem_we;
  mem_banked_pkg::bank_addr_t [NumBanks-1:0] mem_addr;
  mem_banked_pkg::word_t [NumBanks-1:0] mem_wdata;
  mem_banked_pkg::strb_t [NumBanks-1:0] mem_be;
  mem_banked_pkg::word_t [NumBanks-1:0] mem_rdata;

  // Shadow memory indexed by the byte address above the offset
  mem_banked_pkg::word_t shadow [2**IdxWidth];
  mem_banked_pkg::word_t exp_rd_word;
  logic [SelWidth-1:0] wr_sel;
  logic [SelWidth-1:0] rd_sel;
  logic conflict;
  integer seed = Seed;
  int error_count = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int start_errors;

  // Pending port transactions, generated before each test runs
  mem_banked_pkg::addr_t wr_addr_q[$];
  mem_banked_pkg::word_t wr_data_q[$];
  mem_banked_pkg::strb_t wr_strb_q[$];
  mem_banked_pkg::addr_t rd_addr_q[$];

  mem_banked_top #(
    .NumBanks   ( NumBanks   ),
    .MemLatency ( MemLatency )
  ) dut_i (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .wr_req_i    ( wr_req    ),
    .wr_addr_i   ( wr_addr   ),
    .wr_data_i   ( wr_data   ),
    .wr_strb_i   ( wr_strb   ),
    .wr_gnt_o    ( wr_gnt    ),
    .rd_req_i    ( rd_req    ),
    .rd_addr_i   ( rd_addr   ),
    .rd_gnt_o    ( rd_gnt    ),
    .rd_valid_o  ( rd_valid  ),
    .rd_data_o   ( rd_data   ),
    .mem_req_o   ( mem_req   ),
    .mem_gnt_i   ( mem_gnt   ),
    .mem_addr_o  ( mem_addr  ),
    .mem_we_o    ( mem_we    ),
    .mem_wdata_o ( mem_wdata ),
    .mem_be_o    ( mem_be    ),
    .mem_rdata_i ( mem_rdata )
  );

  bank_model #(
    .NumBanks   ( NumBanks   ),
    .MemLatency ( MemLatency ),
    .Seed       ( Seed       )
  ) i_bank_model (
    .clk_i          ( clk          ),
    .always_grant_i ( always_grant ),
    .mem_req_i      ( mem_req      ),
    .mem_gnt_o      ( mem_gnt      ),
    .mem_addr_i     ( mem_addr     ),
    .mem_we_i       ( mem_we       ),
    .mem_wdata_i    ( mem_wdata    ),
    .mem_be_i       ( mem_be       ),
    .mem_rdata_o    ( mem_rdata    )
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  assign wr_sel      = wr_addr[ByteOff +: SelWidth];
  assign rd_sel      = rd_addr[ByteOff +: SelWidth];
  assign exp_rd_word = shadow[rd_addr[ByteOff +: IdxWidth]];
  // Both ports on one bank with no back-pressure
  assign conflict    = always_grant && rd_req && wr_req && (rd_sel == wr_sel);

  // Same fill pattern as the banks
  initial begin
    for (int w = 0; w < 2**IdxWidth; w++) begin
      shadow[w] = {16'hC0DE, 16'(w)};
    end
  end

  // Byte merge on every write port transfer
  always @(posedge clk) begin
    if (rst_n && wr_req && wr_gnt) begin
      for (int i = 0; i < mem_banked_pkg::StrbWidth; i++) begin
        if (wr_strb[i]) begin
          shadow[wr_addr[ByteOff +: IdxWidth]][8*i +: 8] <= wr_data[8*i +: 8];
        end
      end
    end
  end

  // Response exactly MemLatency cycles after each read transfer, never otherwise
  assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid == $past(rd_req && rd_gnt, MemLatency))
  else begin
    error_count++;
    $display("ERROR %0t: rd_valid_o %b off the read latency", $time, $sampled(rd_valid));
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    rd_valid |-> rd_data == $past(exp_rd_word, MemLatency))
  else begin
    error_count++;
    $display("ERROR %0t: read data %h differs from shadow", $time, $sampled(rd_data));
  end

  // Different banks are served in parallel
  assert property (@(posedge clk) disable iff (!rst_n)
    always_grant && rd_req && wr_req && (rd_sel != wr_sel) |-> rd_gnt && wr_gnt)
  else begin
    error_count++;
    $display("ERROR %0t: parallel read and write not both granted", $time);
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    conflict |-> rd_gnt != wr_gnt)
  else begin
    error_count++;
    $display("ERROR %0t: same-bank conflict gave %b%b grants", $time,
             $sampled(rd_gnt), $sampled(wr_gnt));
  end

  // Round-robin, winner flips on back-to-back conflicts
  assert property (@(posedge clk) disable iff (!rst_n)
    conflict && $past(conflict) |-> rd_gnt == $past(wr_gnt))
  else begin
    error_count++;
    $display("ERROR %0t: conflict grants did not alternate", $time);
  end

  for (genvar b = 0; b < NumBanks; b++) begin : gen_lane_check
    // A stalled lane keeps its port and address
    assert property (@(posedge clk) disable iff (!rst_n)
      mem_req[b] && !mem_gnt[b] |=> mem_req[b] && mem_we[b] == $past(mem_we[b])
        && mem_addr[b] == $past(mem_addr[b]))
    else begin
      error_count++;
      $display("ERROR %0t: bank %0d lane changed while stalled", $time, b);
    end

    // Write lane carries the write port word address, data and strobes
    assert property (@(posedge clk) disable iff (!rst_n)
      mem_req[b] && mem_we[b] |-> wr_req && wr_sel == SelWidth'(b)
        && mem_addr[b] == wr_addr[WordLsb +: mem_banked_pkg::BankAddrWidth]
        && mem_wdata[b] == wr_data && mem_be[b] == wr_strb)
    else begin
      error_count++;
      $display("ERROR %0t: bank %0d write lane differs from write port", $time, b);
    end

    // Read lane carries the read word address and no byte enables
    assert property (@(posedge clk) disable iff (!rst_n)
      mem_req[b] && !mem_we[b] |-> rd_req && rd_sel == SelWidth'(b)
        && mem_addr[b] == rd_addr[WordLsb +: mem_banked_pkg::BankAddrWidth]
        && mem_be[b] == '0)
    else begin
      error_count++;
      $display("ERROR %0t: bank %0d read lane differs from read port", $time, b);
    end
  end

  // Random byte address, bank forced when bank is not negative
  function automatic mem_banked_pkg::addr_t rand_addr(input int bank);
    mem_banked_pkg::addr_t a;
    a = $random(seed);
    a[ByteOff-1:0] = '0;
    // Eight words per bank so reads often hit earlier writes
    for (int i = WordLsb + 3; i < WordLsb + mem_banked_pkg::BankAddrWidth; i++) begin
      a[i] = 1'b0;
    end
    if (bank >= 0) begin
      a[ByteOff +: SelWidth] = SelWidth'(bank);
    end
    return a;
  endfunction

  task automatic add_writes(input int count, input int bank);
    for (int n = 0; n < count; n++) begin
      wr_addr_q.push_back(rand_addr(bank));
      wr_data_q.push_back(mem_banked_pkg::word_t'($random(seed)));
      wr_strb_q.push_back(mem_banked_pkg::strb_t'($random(seed)));
    end
  endtask

  task automatic add_reads(input int count, input int bank);
    for (int n = 0; n < count; n++) begin
      rd_addr_q.push_back(rand_addr(bank));
    end
  endtask

  task automatic run_writes();
    int cycles;
    while (wr_addr_q.size() > 0) begin
      @(negedge clk);
      wr_req  = 1'b1;
      wr_addr = wr_addr_q.pop_front();
      wr_data = wr_data_q.pop_front();
      wr_strb = wr_strb_q.pop_front();
      cycles  = 0;
      @(posedge clk);
      while (!wr_gnt && cycles < Timeout) begin
        cycles++;
        @(posedge clk);
      end
      if (!wr_gnt) begin
        error_count++;
        $display("Write port got no grant within %0d cycles", Timeout);
      end
    end
    @(negedge clk);
    wr_req = 1'b0;
  endtask

  task automatic run_reads();
    int cycles;
    while (rd_addr_q.size() > 0) begin
      @(negedge clk);
      rd_req  = 1'b1;
      rd_addr = rd_addr_q.pop_front();
      cycles  = 0;
      @(posedge clk);
      while (!rd_gnt && cycles < Timeout) begin
        cycles++;
        @(posedge clk);
      end
      if (!rd_gnt) begin
        error_count++;
        $display("Read port got no grant within %0d cycles", Timeout);
      end
    end
    @(negedge clk);
    rd_req = 1'b0;
  endtask

  task automatic run_ports();
    fork
      run_writes();
      run_reads();
    join
    // Let the last responses leave the read pipe
    repeat (MemLatency + 2) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (error_count != errors_before) begin
      tests_failed++;
    end
    $display("Test %s done with %0d errors", name, error_count - errors_before);
  endtask

  initial begin
    rst_n        = 1'b0;
    always_grant = 1'b0;
    wr_req       = 1'b0;
    wr_addr      = '0;
    wr_data      = '0;
    wr_strb      = '0;
    rd_req       = 1'b0;
    rd_addr      = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    start_errors = error_count;
    repeat (20) @(negedge clk);
    report_test("reset_idle", start_errors);

    // Random grants, mixed strobes, both ports anywhere
    start_errors = error_count;
    add_writes(80, -1);
    add_reads(80, -1);
    run_ports();
    report_test("write_read_random", start_errors);

    // Back-to-back reads keep MemLatency reads in flight
    start_errors = error_count;
    always_grant = 1'b1;
    add_reads(40, -1);
    run_ports();
    report_test("read_latency", start_errors);

    start_errors = error_count;
    for (int b = 0; b < NumBanks; b++) begin
      add_writes(5, b);
      add_reads(5, (b + 1) % NumBanks);
    end
    run_ports();
    report_test("parallel_banks", start_errors);

    start_errors = error_count;
    add_writes(20, 1);
    add_reads(20, 1);
    run_ports();
    report_test("conflict_fairness", start_errors);

    // Random stalls, ports move between two banks at different rates
    // so one port often arrives at a bank held by the other
    start_errors = error_count;
    always_grant = 1'b0;
    for (int n = 0; n < 30; n++) begin
      add_writes(1, 2 + n % 2);
      add_reads(1, 2 + (n / 2) % 2);
    end
    run_ports();
    report_test("lock_in", start_errors);

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/bank_model.sv
`timescale 1ns/100ps
`default_nettype none

module bank_model #(
  parameter int unsigned NumBanks   = 4,
  parameter int unsigned MemLatency = 1,
  parameter int          Seed       = 57821
) (
  input  wire logic                                 clk_i,
  // Forces every bank grant high
  input  wire logic                                 always_grant_i,
  input  wire logic [NumBanks-1:0]                  mem_req_i,
  output logic [NumBanks-1:0]                       mem_gnt_o,
  input  wire mem_banked_pkg::bank_addr_t [NumBanks-1:0] mem_addr_i,
  input  wire logic [NumBanks-1:0]                  mem_we_i,
  input  wire mem_banked_pkg::word_t [NumBanks-1:0] mem_wdata_i,
  input  wire mem_banked_pkg::strb_t [NumBanks-1:0] mem_be_i,
  output mem_banked_pkg::word_t [NumBanks-1:0]      mem_rdata_o
);

  localparam int unsigned Depth = 2 ** mem_banked_pkg::BankAddrWidth;

  mem_banked_pkg::word_t                mem [NumBanks][Depth];
  // Read data delay line, one stage per cycle of latency
  mem_banked_pkg::word_t [NumBanks-1:0] rdata_q [MemLatency];
  logic [NumBanks-1:0]                  gnt_rand;
  integer                               seed;

  // Fill word built from the full word index {word address, bank}
  initial begin
    seed = Seed;
    gnt_rand = '0;
    for (int b = 0; b < NumBanks; b++) begin
      for (int a = 0; a < Depth; a++) begin
        mem[b][a] = {16'hC0DE, 16'(a * NumBanks + b)};
      end
    end
  end

  // Random back-pressure, changes on the falling edge only
  always @(negedge clk_i) begin
    gnt_rand <= NumBanks'($random(seed));
  end

  assign mem_gnt_o = always_grant_i ? '1 : gnt_rand;

  always @(posedge clk_i) begin
    for (int b = 0; b < NumBanks; b++) begin
      if (mem_req_i[b] && mem_gnt_o[b]) begin
        if (mem_we_i[b]) begin
          // Byte enables merge into the stored word
          for (int i = 0; i < mem_banked_pkg::StrbWidth; i++) begin
            if (mem_be_i[b][i]) begin
              mem[b][mem_addr_i[b]][8*i +: 8] <= mem_wdata_i[b][8*i +: 8];
            end
          end
        end else begin
          rdata_q[0][b] <= mem[b][mem_addr_i[b]];
        end
      end
    end
    for (int i = 1; i < MemLatency; i++) begin
      rdata_q[i] <= rdata_q[i-1];
    end
  end

  assign mem_rdata_o = rdata_q[MemLatency-1];

endmodule

`default_nettype wire

// File: logic/mem_banked_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_banked_top #(
  parameter int unsigned NumBanks   = 4,
  parameter int unsigned MemLatency = 1
) (
  input  wire logic                                      clk_i,
  input  wire logic                                      rst_n_i,
  // Write port, byte addressed
  input  wire logic                                      wr_req_i,
  input  wire mem_banked_pkg::addr_t                     wr_addr_i,
  input  wire mem_banked_pkg::word_t                     wr_data_i,
  input  wire mem_banked_pkg::strb_t                     wr_strb_i,
  output logic                                           wr_gnt_o,
  // Read port, byte addressed
  input  wire logic                                      rd_req_i,
  input  wire mem_banked_pkg::addr_t                     rd_addr_i,
  output logic                                           rd_gnt_o,
  output logic                                           rd_valid_o,
  output mem_banked_pkg::word_t                          rd_data_o,
  // Bank lanes, one per bank
  output logic [NumBanks-1:0]                            mem_req_o,
  input  wire logic [NumBanks-1:0]                       mem_gnt_i,
  output mem_banked_pkg::bank_addr_t [NumBanks-1:0]      mem_addr_o,
  output logic [NumBanks-1:0]                            mem_we_o,
  output mem_banked_pkg::word_t [NumBanks-1:0]           mem_wdata_o,
  output mem_banked_pkg::strb_t [NumBanks-1:0]           mem_be_o,
  input  wire mem_banked_pkg::word_t [NumBanks-1:0]      mem_rdata_i
);

  localparam int unsigned SelWidth = $clog2(NumBanks);
  // Word address starts above byte offset and bank selection
  localparam int unsigned WordAddrLsb = mem_banked_pkg::ByteOffsetWidth + SelWidth;

  logic [SelWidth-1:0]        wr_sel;
  logic [SelWidth-1:0]        rd_sel;
  mem_banked_pkg::bank_addr_t wr_word_addr;
  mem_banked_pkg::bank_addr_t rd_word_addr;
  logic                       rd_fire;

  // Address split, low bits interleave words across banks
  assign wr_sel       = wr_addr_i[mem_banked_pkg::ByteOffsetWidth +: SelWidth];
  assign rd_sel       = rd_addr_i[mem_banked_pkg::ByteOffsetWidth +: SelWidth];
  // Bits above the word address are ignored
  assign wr_word_addr = wr_addr_i[WordAddrLsb +: mem_banked_pkg::BankAddrWidth];
  assign rd_word_addr = rd_addr_i[WordAddrLsb +: mem_banked_pkg::BankAddrWidth];

  // Read transfer on the port side
  assign rd_fire = rd_req_i & rd_gnt_o;

  bank_xbar #(
    .NumBanks ( NumBanks )
  ) i_bank_xbar (
    .clk_i       ( clk_i        ),
    .rst_n_i     ( rst_n_i      ),
    .wr_req_i    ( wr_req_i     ),
    .wr_sel_i    ( wr_sel       ),
    .wr_addr_i   ( wr_word_addr ),
    .wr_data_i   ( wr_data_i    ),
    .wr_strb_i   ( wr_strb_i    ),
    .wr_gnt_o    ( wr_gnt_o     ),
    .rd_req_i    ( rd_req_i     ),
    .rd_sel_i    ( rd_sel       ),
    .rd_addr_i   ( rd_word_addr ),
    .rd_gnt_o    ( rd_gnt_o     ),
    .mem_req_o   ( mem_req_o    ),
    .mem_gnt_i   ( mem_gnt_i    ),
    .mem_addr_o  ( mem_addr_o   ),
    .mem_we_o    ( mem_we_o     ),
    .mem_wdata_o ( mem_wdata_o  ),
    .mem_be_o    ( mem_be_o     )
  );

  // Response routing, MemLatency cycles after the read transfer
  read_resp_pipe #(
    .NumBanks   ( NumBanks   ),
    .MemLatency ( MemLatency )
  ) i_read_resp_pipe (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .rd_fire_i   ( rd_fire     ),
    .rd_sel_i    ( rd_sel      ),
    .mem_rdata_i ( mem_rdata_i ),
    .rd_valid_o  ( rd_valid_o  ),
    .rd_data_o   ( rd_data_o   )
  );

endmodule

`default_nettype wire

// File: logic/read_resp_pipe.sv
`timescale 1ns/100ps
`default_nettype none

module read_resp_pipe #(
  parameter int unsigned NumBanks   = 4,
  parameter int unsigned MemLatency = 1
) (
  input  wire logic                                 clk_i,
  input  wire logic                                 rst_n_i,
  // Read port transfer and its target bank
  input  wire logic                                 rd_fire_i,
  input  wire logic [$clog2(NumBanks)-1:0]          rd_sel_i,
  // Read data of all banks
  input  wire mem_banked_pkg::word_t [NumBanks-1:0] mem_rdata_i,
  output logic                                      rd_valid_o,
  output mem_banked_pkg::word_t                     rd_data_o
);

  localparam int unsigned SelWidth = $clog2(NumBanks);

  // One stage per cycle of bank latency
  logic [MemLatency-1:0]               valid_q;
  logic [MemLatency-1:0][SelWidth-1:0] sel_q;

  // Valid bits, cleared by reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= rd_fire_i;
      for (int i = 1; i < MemLatency; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Bank selection travels alongside the valid bit
  always_ff @(posedge clk_i) begin
    sel_q[0] <= rd_sel_i;
    for (int i = 1; i < MemLatency; i++) begin
      sel_q[i] <= sel_q[i-1];
    end
  end

  // Last stage lines up with the bank read data
  assign rd_valid_o = valid_q[MemLatency-1];
  // Route the data of the bank that served the read
  assign rd_data_o  = mem_rdata_i[sel_q[MemLatency-1]];

endmodule

`default_nettype wire

// File: logic/bank_xbar.sv
`timescale 1ns/100ps
`default_nettype none

module bank_xbar #(
  parameter int unsigned NumBanks = 4
) (
  input  wire logic                                      clk_i,
  input  wire logic                                      rst_n_i,
  // Write port, already split into bank and word address
  input  wire logic                                      wr_req_i,
  input  wire logic [$clog2(NumBanks)-1:0]               wr_sel_i,
  input  wire mem_banked_pkg::bank_addr_t                wr_addr_i,
  input  wire mem_banked_pkg::word_t                     wr_data_i,
  input  wire mem_banked_pkg::strb_t                     wr_strb_i,
  output logic                                           wr_gnt_o,
  // Read port
  input  wire logic                                      rd_req_i,
  input  wire logic [$clog2(NumBanks)-1:0]               rd_sel_i,
  input  wire mem_banked_pkg::bank_addr_t                rd_addr_i,
  output logic                                           rd_gnt_o,
  // Bank lanes
  output logic [NumBanks-1:0]                            mem_req_o,
  input  wire logic [NumBanks-1:0]                       mem_gnt_i,
  output mem_banked_pkg::bank_addr_t [NumBanks-1:0]      mem_addr_o,
  output logic [NumBanks-1:0]                            mem_we_o,
  output mem_banked_pkg::word_t [NumBanks-1:0]           mem_wdata_o,
  output mem_banked_pkg::strb_t [NumBanks-1:0]           mem_be_o
);

  localparam int unsigned SelWidth = $clog2(NumBanks);

  // Per-bank port grants, ORed below
  logic [NumBanks-1:0] rd_gnt_bank;
  logic [NumBanks-1:0] wr_gnt_bank;

  for (genvar b = 0; b < NumBanks; b++) begin : gen_bank
    logic rd_hit;
    logic wr_hit;
    logic rd_win;
    logic wr_win;

    // Which ports target this bank
    assign rd_hit = rd_req_i && (rd_sel_i == SelWidth'(b));
    assign wr_hit = wr_req_i && (wr_sel_i == SelWidth'(b));

    bank_arbiter i_bank_arbiter (
      .clk_i      ( clk_i        ),
      .rst_n_i    ( rst_n_i      ),
      .rd_req_i   ( rd_hit       ),
      .wr_req_i   ( wr_hit       ),
      .bank_gnt_i ( mem_gnt_i[b] ),
      .rd_win_o   ( rd_win       ),
      .wr_win_o   ( wr_win       )
    );

    // Lane follows the winner
    assign mem_req_o[b]   = rd_win | wr_win;
    assign mem_we_o[b]    = wr_win;
    assign mem_addr_o[b]  = wr_win ? wr_addr_i : rd_addr_i;
    // Reads carry no data and no byte enables
    assign mem_wdata_o[b] = wr_win ? wr_data_i : '0;
    assign mem_be_o[b]    = wr_win ? wr_strb_i : '0;

    // Port grant only together with the bank grant
    assign rd_gnt_bank[b] = rd_win & mem_gnt_i[b];
    assign wr_gnt_bank[b] = wr_win & mem_gnt_i[b];
  end

  assign rd_gnt_o = |rd_gnt_bank;
  assign wr_gnt_o = |wr_gnt_bank;

endmodule

`default_nettype wire

// File: logic/bank_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module bank_arbiter (
  input  wire logic clk_i,
  input  wire logic rst_n_i,
  // Port requests already decoded for this bank
  input  wire logic rd_req_i,
  input  wire logic wr_req_i,
  // Grant of the bank itself
  input  wire logic bank_gnt_i,
  // At most one of these is high
  output logic      rd_win_o,
  output logic      wr_win_o
);

  mem_banked_pkg::arb_state_e state_q, state_d;
  // Set when the write port took the last granted transfer
  logic last_wr_q, last_wr_d;

  // Winner selection
  always_comb begin
    rd_win_o = 1'b0;
    wr_win_o = 1'b0;
    case (state_q)
      // Lock-in, the held port keeps the bank
      mem_banked_pkg::ArbHoldRd: rd_win_o = rd_req_i;
      mem_banked_pkg::ArbHoldWr: wr_win_o = wr_req_i;
      default: begin
        if (rd_req_i && wr_req_i) begin
          // Conflict goes to the port that lost last time
          rd_win_o = last_wr_q;
          wr_win_o = !last_wr_q;
        end else begin
          rd_win_o = rd_req_i;
          wr_win_o = wr_req_i;
        end
      end
    endcase
  end

  // Next state and round-robin pointer
  always_comb begin
    state_d   = mem_banked_pkg::ArbFree;
    last_wr_d = last_wr_q;
    // Winner not granted, lock the bank to it
    if (rd_win_o && !bank_gnt_i) begin
      state_d = mem_banked_pkg::ArbHoldRd;
    end else if (wr_win_o && !bank_gnt_i) begin
      state_d = mem_banked_pkg::ArbHoldWr;
    end
    // Pointer moves only on a real bank transfer
    if ((rd_win_o || wr_win_o) && bank_gnt_i) begin
      last_wr_d = wr_win_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= mem_banked_pkg::ArbFree;
      // Read port has priority after reset
      last_wr_q <= 1'b1;
    end else begin
      state_q   <= state_d;
      last_wr_q <= last_wr_d;
    end
  end

endmodule

`default_nettype wire

// File: logic/mem_banked_pkg.sv
`default_nettype none

package mem_banked_pkg;

  // Width of one memory word and of the port data
  localparam int unsigned DataWidth = 32;
  // One byte enable per data byte
  localparam int unsigned StrbWidth = DataWidth / 8;
  // Byte offset inside a word, below the bank selection
  localparam int unsigned ByteOffsetWidth = $clog2(StrbWidth);
  // Word address inside one bank, 256 words deep
  localparam int unsigned BankAddrWidth = 8;
  // Byte address width of both ports
  localparam int unsigned AddrWidth = 32;

  // Data word as seen by ports and banks
  typedef logic [DataWidth-1:0] word_t;
  // Byte enables, active high
  typedef logic [StrbWidth-1:0] strb_t;
  // Word address inside a bank
  typedef logic [BankAddrWidth-1:0] bank_addr_t;
  // Byte address on the ports
  typedef logic [AddrWidth-1:0] addr_t;

  // Per-bank arbiter state
  // Hold states keep the bank with one port until the bank grants
  typedef enum logic [1:0] {
    ArbFree   = 2'd0,
    ArbHoldRd = 2'd1,
    ArbHoldWr = 2'd2
  } arb_state_e;

endpackage

`default_nettype wire
